// File: verilog/armPkg.sv
`default_nettype none

package armPkg;

  typedef logic [31:0] wordT;  // Data or address word
  typedef logic [3:0] regAddrT;  // Register number

  localparam regAddrT pcReg = 4'd15;  // PC register

  // Kept data-processing opcodes, ARM encoding
  typedef enum logic [3:0] {
    opAnd = 4'h0,
    opEor = 4'h1,
    opSub = 4'h2,
    opAdd = 4'h4,
    opOrr = 4'hc,
    opMov = 4'hd
  } aluOpT;

  // Register operand form
  typedef struct packed {
    logic [3:0] cond;  // Condition field, not evaluated
    logic [1:0] instrClass;  // 00 for data processing
    logic       immFlag;  // Clear in this form
    logic [3:0] opcode;
    logic       setFlags;
    regAddrT    rn;  // First source
    regAddrT    rd;  // Destination
    logic [7:0] shift;  // Shift amount and type
    regAddrT    rm;  // Second source
  } dpRegT;

  // Immediate operand form
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] instrClass;
    logic       immFlag;  // Set in this form
    logic [3:0] opcode;
    logic       setFlags;
    regAddrT    rn;
    regAddrT    rd;
    logic [3:0] rotate;  // Not applied
    logic [7:0] imm8;  // Zero-extended operand
  } dpImmT;

  // One instruction word, read through the member chosen by immFlag
  typedef union packed {
    dpRegT regForm;
    dpImmT immForm;
  } instrU;

  typedef struct packed {
    aluOpT aluOp;
    logic  immSel;  // Operand B from the immediate
    logic  regWrite;  // Result is written back
  } ctrlT;

  // Execute operand source
  typedef enum logic [1:0] {
    fromRegs = 2'b00,
    fromWb   = 2'b01,
    fromMem  = 2'b10
  } fwdSelT;

  // Retired register write, also used for forward destinations
  typedef struct packed {
    logic    valid;
    regAddrT rd;
    wordT    data;
  } retireT;

endpackage

`default_nettype wire

// File: verilog/fetchCounter.sv
`timescale 1ns/1ps
`default_nettype none

module fetchCounter #(
  parameter armPkg::wordT resetPc = '0  // First fetch address
) (
  input  wire          clk,
  input  wire          rstN,
  output armPkg::wordT pcF,  // Current fetch address
  output armPkg::wordT pcPlus4  // Next address, also r15 seen in decode
);

  import armPkg::*;

  // Sequential fetch only
  assign pcPlus4 = pcF + 32'd4;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= resetPc;
    end else begin
      pcF <= pcPlus4;  // Steps every cycle, wraps at 2^32
    end
  end

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  armPkg::instrU   instrD,  // Instruction in decode
  output armPkg::ctrlT    ctrl,
  output armPkg::regAddrT rnD,  // Operand A register
  output armPkg::regAddrT rmD,  // Operand B register, register form
  output armPkg::regAddrT rdD,  // Destination
  output armPkg::wordT    immD  // Zero-extended imm8
);

  import armPkg::*;

  logic    isImm;
  logic    opKept;  // Opcode is in the supported set
  regAddrT dst;

  assign isImm = instrD.regForm.immFlag;  // Same bit in both forms

  // Rn and Rd sit at the same bits in both forms
  assign rnD = instrD.regForm.rn;
  assign dst = instrD.regForm.rd;

  assign rdD  = dst;
  assign rmD  = instrD.regForm.rm;  // Don't care in immediate form
  assign immD = {24'd0, instrD.immForm.imm8};  // No rotation

  always_comb begin
    opKept     = 1'b1;
    ctrl.aluOp = opAnd;
    case (instrD.regForm.opcode)
      4'h0: ctrl.aluOp = opAnd;
      4'h1: ctrl.aluOp = opEor;
      4'h2: ctrl.aluOp = opSub;
      4'h4: ctrl.aluOp = opAdd;
      4'hc: ctrl.aluOp = opOrr;
      4'hd: ctrl.aluOp = opMov;  // Rn still decoded, ALU passes B only
      default: opKept = 1'b0;  // RSB, ADC, CMP and others
    endcase
    ctrl.immSel = isImm;
    // Only place where r15 writes are dropped
    ctrl.regWrite = opKept && (dst != pcReg);
  end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire             clk,
  input  wire             rstN,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  wire             we,  // Write enable from writeback
  input  armPkg::regAddrT wa,
  input  armPkg::wordT    wd,
  input  armPkg::wordT    r15,  // PC+8 of the decoding instruction
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);

  import armPkg::*;

  wordT regs [0:14];  // r0..r14

  // Read port with r15 value and write-through
  function automatic wordT readPort(input regAddrT ra);
    wordT val;
    if (ra == pcReg) begin
      val = r15;
    end else if (we && (wa == ra)) begin
      val = wd;  // Same-cycle writeback seen by decode
    end else begin
      val = regs[ra];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;  // wa never 15 when we is set
    end
  end

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule

`default_nettype wire

// File: verilog/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
  input  armPkg::regAddrT rnE,
  input  armPkg::regAddrT rmE,
  input  armPkg::wordT    rd1E,  // Register read of Rn
  input  armPkg::wordT    rd2E,  // Register read of Rm
  input  armPkg::retireT  memDst,  // Memory stage result
  input  armPkg::retireT  wbDst,  // Writeback stage result
  output armPkg::wordT    srcA,
  output armPkg::wordT    writeData
);

  import armPkg::*;

  fwdSelT selA;
  fwdSelT selB;

  // Youngest matching producer wins
  function automatic fwdSelT pickSrc(input regAddrT src);
    fwdSelT sel;
    if (memDst.valid && (memDst.rd == src)) begin
      sel = fromMem;
    end else if (wbDst.valid && (wbDst.rd == src)) begin
      sel = fromWb;
    end else begin
      sel = fromRegs;
    end
    return sel;
  endfunction

  function automatic wordT bypass(input fwdSelT sel, input wordT regVal);
    wordT val;
    case (sel)
      fromMem: val = memDst.data;
      fromWb:  val = wbDst.data;
      default: val = regVal;
    endcase
    return val;
  endfunction

  always_comb begin
    selA      = pickSrc(rnE);
    selB      = pickSrc(rmE);
    srcA      = bypass(selA, rd1E);
    writeData = bypass(selB, rd2E);  // Operand B before immediate select
  end

endmodule

`default_nettype wire

// File: verilog/execAlu.sv
`timescale 1ns/1ps
`default_nettype none

module execAlu (
  input  armPkg::ctrlT ctrlE,
  input  armPkg::wordT srcA,  // Forwarded Rn
  input  armPkg::wordT writeData,  // Forwarded Rm
  input  armPkg::wordT immE,  // Extended immediate
  output armPkg::wordT aluResult
);

  import armPkg::*;

  wordT srcB;

  assign srcB = ctrlE.immSel ? immE : writeData;

  always_comb begin
    case (ctrlE.aluOp)
      opAnd:   aluResult = srcA & srcB;
      opEor:   aluResult = srcA ^ srcB;
      opSub:   aluResult = srcA - srcB;  // A minus B
      opAdd:   aluResult = srcA + srcB;
      opOrr:   aluResult = srcA | srcB;
      opMov:   aluResult = srcB;
      default: aluResult = srcB;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/armPipe.sv
`timescale 1ns/1ps
`default_nettype none

module armPipe #(
  parameter armPkg::wordT resetPc = '0
) (
  input  wire            clk,
  input  wire            rstN,
  output armPkg::wordT   pcF,  // Instruction memory address
  input  armPkg::wordT   instrF,  // Instruction at pcF, same cycle
  output armPkg::retireT retire  // Writeback result
);

  import armPkg::*;

  // Decode to execute payload
  typedef struct packed {
    logic    valid;
    ctrlT    ctrl;
    regAddrT rn;
    regAddrT rm;
    regAddrT rd;
    wordT    rd1;
    wordT    rd2;
    wordT    imm;
  } execStageT;

  // Memory and writeback payload
  typedef struct packed {
    logic    valid;
    logic    regWrite;
    regAddrT rd;
    wordT    result;
  } resultStageT;

  wordT        pcPlus4;  // PC+8 of the instruction in decode
  instrU       instrD;
  logic        validD;
  ctrlT        ctrlD;
  regAddrT     rnD;
  regAddrT     rmD;
  regAddrT     rdD;
  wordT        immD;
  wordT        rd1D;
  wordT        rd2D;
  execStageT   exStage;
  wordT        srcA;
  wordT        writeData;
  wordT        aluResult;
  resultStageT memStage;
  resultStageT wbStage;
  retireT      memDst;
  retireT      wbDst;

  fetchCounter #(
    .resetPc(resetPc)
  ) fetchCounter_inst (
    .clk    (clk),
    .rstN   (rstN),
    .pcF    (pcF),
    .pcPlus4(pcPlus4)
  );

  // Fetch to decode
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrD <= '0;
      validD <= 1'b0;
    end else begin
      instrD <= instrF;
      validD <= 1'b1;  // Every fetch is sequential and valid
    end
  end

  instrDecoder instrDecoder_inst (
    .instrD(instrD),
    .ctrl  (ctrlD),
    .rnD   (rnD),
    .rmD   (rmD),
    .rdD   (rdD),
    .immD  (immD)
  );

  regFile regFile_inst (
    .clk (clk),
    .rstN(rstN),
    .ra1 (rnD),
    .ra2 (rmD),
    .we  (wbDst.valid),
    .wa  (wbDst.rd),
    .wd  (wbDst.data),
    .r15 (pcPlus4),  // pcF is already one word ahead of decode
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // Decode to execute
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exStage <= '0;
    end else begin
      exStage <= '{valid: validD, ctrl: ctrlD, rn: rnD, rm: rmD, rd: rdD,
                   rd1: rd1D, rd2: rd2D, imm: immD};
    end
  end

  // Producers seen by execute, valid only when they write
  assign memDst = '{valid: memStage.valid && memStage.regWrite,
                    rd: memStage.rd, data: memStage.result};
  assign wbDst  = '{valid: wbStage.valid && wbStage.regWrite,
                    rd: wbStage.rd, data: wbStage.result};

  forwardUnit forwardUnit_inst (
    .rnE      (exStage.rn),
    .rmE      (exStage.rm),
    .rd1E     (exStage.rd1),
    .rd2E     (exStage.rd2),
    .memDst   (memDst),
    .wbDst    (wbDst),
    .srcA     (srcA),
    .writeData(writeData)
  );

  execAlu execAlu_inst (
    .ctrlE    (exStage.ctrl),
    .srcA     (srcA),
    .writeData(writeData),
    .immE     (exStage.imm),
    .aluResult(aluResult)
  );

  // Execute to memory, then memory to writeback
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memStage <= '0;
      wbStage  <= '0;
    end else begin
      memStage <= '{valid: exStage.valid, regWrite: exStage.ctrl.regWrite,
                    rd: exStage.rd, result: aluResult};
      wbStage  <= memStage;  // No data memory, result passes through
    end
  end

  assign retire = wbDst;  // Same value that is written to regFile

endmodule

`default_nettype wire

// File: dv/armPipe_sva.sv
`timescale 1ns/1ps
`default_nettype none

module armPipeSva (
  input wire            clk,
  input wire            rstN,
  input armPkg::wordT   pcF,
  input armPkg::retireT retire
);

  import armPkg::*;

  // Stage registers are cleared by each reset edge
  resetQuiet: assert property (@(posedge clk) !rstN |=> !retire.valid)
    else $error("retire valid set during reset");

  noPcWrite: assert property (@(posedge clk) disable iff (!rstN)
    retire.valid |-> (retire.rd != pcReg))
    else $error("retire names register 15");

  pcStep: assert property (@(posedge clk) disable iff (!rstN)
    $past(rstN) |-> (pcF == $past(pcF) + 32'd4))
    else $error("pcF did not advance by four");

endmodule

`default_nettype wire

// File: dv/retireChecker.sv
`timescale 1ns/1ps
`default_nettype none

module retireChecker #(
  parameter armPkg::wordT resetPc = '0
) (
  input  wire            clk,
  input  wire            rstN,
  input  armPkg::wordT   pcF,
  input  armPkg::retireT retire,
  input  armPkg::wordT   progMem [0:255],
  output int             mismatchCount,
  output int             otherCount,  // Timeouts and protocol errors
  output logic           done
);

  import armPkg::*;

  localparam int numRetires = 400;
  localparam int waitLimit  = 64;  // Cycles allowed between two retires

  wordT modelRegs [0:14];  // Sequential reference registers
  int   cycle;  // Negedges since reset release

  // r15 reads give the instruction address plus eight
  function automatic wordT readModel(input logic [3:0] r, input wordT pc);
    return (r == 4'd15) ? pc + 32'd8 : modelRegs[r];
  endfunction

  function automatic wordT aluModel(input logic [3:0] op, input wordT a, input wordT b);
    case (op)
      4'h0: return a & b;
      4'h1: return a ^ b;
      4'h2: return a - b;
      4'h4: return a + b;
      4'hc: return a | b;
      default: return b;  // MOV
    endcase
  endfunction

  task automatic checkPc();
    wordT expPc;
    expPc = resetPc + 32'(4 * cycle);  // One word per cycle, no stalls
    if (pcF !== expPc) begin
      $display("MISMATCH test=pcStep%0d expected=%h actual=%h", cycle, expPc, pcF);
      mismatchCount++;
    end
  endtask

  task automatic nextCycle();
    @(negedge clk);  // Outputs settled, inputs change after posedge
    cycle++;
    checkPc();
  endtask

  initial begin : runModel
    wordT    instr;
    wordT    modelPc;
    wordT    expData;
    regAddrT expRd;
    logic    writes;
    logic    stop;
    int      seq;
    int      expSeq;
    int      steps;
    int      waited;
    int      matched;
    mismatchCount = 0;
    otherCount    = 0;
    done          = 1'b0;
    cycle         = 0;
    stop          = 1'b0;
    seq           = 0;
    matched       = 0;
    modelPc       = resetPc;
    for (int i = 0; i < 15; i++) begin
      modelRegs[i] = '0;
    end
    waited = 0;
    @(negedge clk);
    while (rstN !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rstN !== 1'b1) begin
      $display("ERROR: reset was not released within %0d cycles", waited);
      otherCount++;
      stop = 1'b1;
    end else begin
      checkPc();  // Cycle 0 must show resetPc
      if (retire.valid !== 1'b0) begin
        $display("ERROR: retire valid is set right after reset");
        otherCount++;
      end
    end
    while (!stop && matched < numRetires) begin
      writes = 1'b0;
      steps  = 0;
      // Step the model up to its next register write
      while (!writes && steps < waitLimit) begin
        instr   = progMem[modelPc[9:2]];  // Wraps over the 256 words
        expRd   = instr[15:12];
        expData = aluModel(instr[24:21], readModel(instr[19:16], modelPc),
                           instr[25] ? {24'd0, instr[7:0]} : readModel(instr[3:0], modelPc));
        writes  = (instr[24:21] inside {4'h0, 4'h1, 4'h2, 4'h4, 4'hc, 4'hd}) &&
                  (expRd != 4'd15);
        if (writes) begin
          modelRegs[expRd] = expData;
        end
        expSeq  = seq;
        seq++;
        modelPc = modelPc + 32'd4;
        steps++;
      end
      nextCycle();
      waited = 1;
      while (retire.valid !== 1'b1 && waited < waitLimit) begin
        nextCycle();
        waited++;
      end
      if (!writes || retire.valid !== 1'b1) begin
        $display("ERROR: no retire within %0d cycles after retire %0d", waited, matched);
        otherCount++;
        stop = 1'b1;
      end else begin
        if (retire.rd !== expRd || retire.data !== expData) begin
          $display("MISMATCH test=retire%0d_op%h_imm%0d expected=r%0d:%h actual=r%0d:%h",
                   matched, instr[24:21], instr[25], expRd, expData, retire.rd, retire.data);
          mismatchCount++;
        end
        if (cycle != expSeq + 4) begin  // Fixed four-edge latency
          $display("MISMATCH test=latency%0d expected=%0d actual=%0d",
                   matched, expSeq + 4, cycle);
          mismatchCount++;
        end
        matched++;
      end
    end
    done = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tbArmPipe.sv
`timescale 1ns/1ps
`default_nettype none

module tbArmPipe;

  import armPkg::*;

  localparam wordT startPc = 32'h0000_0040;  // Starts at word 16 of the memory

  logic   clk;
  logic   rstN;
  wordT   pcF;
  wordT   instrF;
  retireT retire;
  wordT   progMem [0:255];  // Instruction memory, word addressed
  int     mismatchCount;
  int     otherCount;
  logic   chkDone;

  armPipe #(.resetPc(startPc)) armPipe_inst (
    .clk(clk), .rstN(rstN), .pcF(pcF), .instrF(instrF), .retire(retire)
  );

  retireChecker #(.resetPc(startPc)) retireChecker_inst (
    .clk(clk), .rstN(rstN), .pcF(pcF), .retire(retire), .progMem(progMem),
    .mismatchCount(mismatchCount), .otherCount(otherCount), .done(chkDone)
  );

  bind armPipe armPipeSva armPipeSva_inst (.clk(clk), .rstN(rstN), .pcF(pcF), .retire(retire));

  // Mostly r0..r3 so that hazards are dense
  function automatic regAddrT pickReg();
    if ($urandom_range(7) == 0) return 4'd15;  // PC read or dropped write
    return 4'($urandom_range(3));
  endfunction

  task automatic fillProgram();
    logic       immFlag;
    logic [3:0] op;
    for (int i = 0; i < 256; i++) begin
      immFlag = 1'($urandom_range(1));
      case ($urandom_range(7))
        0: op = 4'h0;  // AND
        1: op = 4'h1;  // EOR
        2: op = 4'h2;  // SUB
        3: op = 4'h4;  // ADD
        4: op = 4'hc;  // ORR
        5: op = 4'hd;  // MOV
        default: op = 4'($urandom_range(15));  // Often outside the kept set
      endcase
      // cond, class 00, I, opcode, S, Rn, Rd
      progMem[i][31:12] = {4'($urandom), 2'b00, immFlag, op, 1'($urandom_range(1)),
                           pickReg(), pickReg()};
      if (immFlag) begin
        progMem[i][11:0] = 12'($urandom);  // Rotate field is ignored
      end else begin
        progMem[i][11:0] = {8'($urandom), pickReg()};  // Shift bits then Rm
      end
    end
  endtask

  initial begin : clockGen
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  initial begin : stimulus
    rstN = 1'b0;
    void'($urandom(32'h5fb4ed40));
    fillProgram();
    repeat (2) @(posedge clk);
    #1 rstN = 1'b1;
  end

  // Memory read of the current pcF, applied just after the edge
  initial begin : fetchMem
    instrF = '0;
    forever begin
      @(posedge clk);
      #1 instrF = progMem[pcF[9:2]];
    end
  end

  initial begin : finishRun
    int waitCycles;
    waitCycles = 0;
    while (chkDone !== 1'b1 && waitCycles < 5000) begin
      @(posedge clk);
      waitCycles++;
    end
    if (chkDone !== 1'b1) begin
      $display("ERROR: checker did not finish within %0d cycles", waitCycles);
    end
    $display("Errors: mismatches=%0d other=%0d timeout=%0d", mismatchCount, otherCount,
             chkDone !== 1'b1);
    if (chkDone === 1'b1 && mismatchCount == 0 && otherCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/armPkg.sv
verilog/fetchCounter.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/forwardUnit.sv
verilog/execAlu.sv
verilog/armPipe.sv
dv/armPipe_sva.sv
dv/retireChecker.sv
dv/tbArmPipe.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbArmPipe \
  -f tb.f -o simArmPipe > sim.log 2>&1 \
  && ./obj_dir/simArmPipe >> sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }
